/* src/rv_ctrl_pkg.sv */
// rv_ctrl shared definitions
// opcodes, field widths, forward select codes and the instruction word views
package rv_ctrl_pkg;

    // widths
    localparam int unsigned XLEN  = 32;   // data / address width
    localparam int unsigned REG_W = 5;    // register index
    localparam int unsigned FWD_W = 2;    // forward select

    // RV32I major opcodes, inst[6:0]
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;

    // branch funct3, only the equality pair is judged in ID
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // forward selects
    // 11 is never produced
    localparam logic [FWD_W-1:0] FWD_NONE   = 2'b00;  // register file / ID-EX value
    localparam logic [FWD_W-1:0] FWD_MEM_WB = 2'b01;  // writeback value
    localparam logic [FWD_W-1:0] FWD_EX_MEM = 2'b10;  // ALU result in EX/MEM

    // J-type view
    typedef struct packed {
        logic       imm20;      // sign bit
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // B-type view
    typedef struct packed {
        logic       imm12;      // sign bit
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // one word, two decodes
    // opcode sits at [6:0] in both
    typedef union packed {
        j_fmt_t j_fmt;
        b_fmt_t b_fmt;
    } inst_word_t;

endpackage

/* src/hazard_if.sv */
// pipeline register snapshot bundle
// ID/EX, EX/MEM and MEM/WB fields the hazard logic looks at
`timescale 1ns/10ps

interface hazard_if;

    // ID/EX, the instruction now in EX
    logic [rv_ctrl_pkg::REG_W-1:0] id_ex_rd;
    logic [rv_ctrl_pkg::REG_W-1:0] id_ex_rs1;
    logic [rv_ctrl_pkg::REG_W-1:0] id_ex_rs2;
    logic                          id_ex_reg_w;
    logic                          id_ex_mem_read;    // load in EX

    // EX/MEM
    logic [rv_ctrl_pkg::REG_W-1:0] ex_mem_rd;
    logic                          ex_mem_reg_w;
    logic                          ex_mem_mem_read;   // load in MEM, data not ready yet

    // MEM/WB
    logic [rv_ctrl_pkg::REG_W-1:0] mem_wb_rd;
    logic                          mem_wb_reg_w;

    // driver side, fed from the top ports
    modport src (
        output id_ex_rd, id_ex_rs1, id_ex_rs2, id_ex_reg_w, id_ex_mem_read,
        output ex_mem_rd, ex_mem_reg_w, ex_mem_mem_read,
        output mem_wb_rd, mem_wb_reg_w
    );

    // hazard detector side, read only
    modport hzd (
        input  id_ex_rd, id_ex_rs1, id_ex_rs2, id_ex_reg_w, id_ex_mem_read,
        input  ex_mem_rd, ex_mem_reg_w, ex_mem_mem_read,
        input  mem_wb_rd, mem_wb_reg_w
    );

endinterface

/* src/inst_classifier.sv */
// instruction classifier for the ID stage
// opcode class, rs fields, register usage and J/B immediate
`timescale 1ns/10ps

module inst_classifier (
    input  rv_ctrl_pkg::inst_word_t         inst_i,
    output logic [rv_ctrl_pkg::REG_W-1:0]   rs1_o,
    output logic [rv_ctrl_pkg::REG_W-1:0]   rs2_o,
    output logic                            uses_rs1_o,
    output logic                            uses_rs2_o,
    output logic                            is_jal_o,
    output logic                            is_beq_o,
    output logic                            is_bne_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]    imm_o
);

    logic [6:0]                  opcode;
    logic                        is_branch;
    logic [rv_ctrl_pkg::XLEN-1:0] imm_j;
    logic [rv_ctrl_pkg::XLEN-1:0] imm_b;

    assign opcode    = inst_i.b_fmt.opcode;    // same bits in j_fmt
    assign is_branch = (opcode == rv_ctrl_pkg::OPC_BRANCH);
    assign is_jal_o  = (inst_i.j_fmt.opcode == rv_ctrl_pkg::OPC_JAL);

    // only beq/bne are judged early, other funct3 pass as plain instructions
    assign is_beq_o = is_branch && (inst_i.b_fmt.funct3 == rv_ctrl_pkg::F3_BEQ);
    assign is_bne_o = is_branch && (inst_i.b_fmt.funct3 == rv_ctrl_pkg::F3_BNE);

    assign rs1_o = inst_i.b_fmt.rs1;
    assign rs2_o = inst_i.b_fmt.rs2;

    // register usage per class
    always_comb begin
        uses_rs1_o = 1'b1;                 // default, unknown opcodes too
        uses_rs2_o = 1'b0;
        case (opcode)
            rv_ctrl_pkg::OPC_JAL,
            rv_ctrl_pkg::OPC_LUI,
            rv_ctrl_pkg::OPC_AUIPC:  uses_rs1_o = 1'b0;  // no source registers
            rv_ctrl_pkg::OPC_BRANCH,
            rv_ctrl_pkg::OPC_STORE,
            rv_ctrl_pkg::OPC_OP:     uses_rs2_o = 1'b1;  // two sources
            rv_ctrl_pkg::OPC_JALR,
            rv_ctrl_pkg::OPC_LOAD,
            rv_ctrl_pkg::OPC_OP_IMM: uses_rs1_o = 1'b1;  // rs1 only
            default:                 uses_rs1_o = 1'b1;
        endcase
    end

    // sign extended, bit 0 always clear
    assign imm_j = {{12{inst_i.j_fmt.imm20}}, inst_i.j_fmt.imm19_12,
                    inst_i.j_fmt.imm11, inst_i.j_fmt.imm10_1, 1'b0};
    assign imm_b = {{20{inst_i.b_fmt.imm12}}, inst_i.b_fmt.imm11,
                    inst_i.b_fmt.imm10_5, inst_i.b_fmt.imm4_1, 1'b0};

    assign imm_o = is_jal_o  ? imm_j :
                   is_branch ? imm_b : '0;     // zero for anything else

endmodule

/* src/fwd_ctrl.sv */
// forward and stall control
// EX forward selects, decode compare selects, load-use and branch stalls
`timescale 1ns/10ps

module fwd_ctrl (
    hazard_if.hzd                          hzd,
    input  logic [rv_ctrl_pkg::REG_W-1:0]  rs1_i,
    input  logic [rv_ctrl_pkg::REG_W-1:0]  rs2_i,
    input  logic                           uses_rs1_i,
    input  logic                           uses_rs2_i,
    input  logic                           is_beq_i,
    input  logic                           is_bne_i,
    output logic [rv_ctrl_pkg::FWD_W-1:0]  fwd_a_o,
    output logic [rv_ctrl_pkg::FWD_W-1:0]  fwd_b_o,
    output logic [rv_ctrl_pkg::FWD_W-1:0]  cmp_sel_a_o,
    output logic [rv_ctrl_pkg::FWD_W-1:0]  cmp_sel_b_o,
    output logic                           stall_o
);

    // writer hits a source register, x0 never counts
    function automatic logic reg_hit(
        input logic                          wr_en,
        input logic [rv_ctrl_pkg::REG_W-1:0] wr_rd,
        input logic [rv_ctrl_pkg::REG_W-1:0] src
    );
        return wr_en && (wr_rd != '0) && (wr_rd == src);
    endfunction

    // EX/MEM is younger so it wins
    function automatic logic [rv_ctrl_pkg::FWD_W-1:0] pick_fwd(
        input logic ex_hit,
        input logic wb_hit
    );
        if (ex_hit)
            return rv_ctrl_pkg::FWD_EX_MEM;
        else if (wb_hit)
            return rv_ctrl_pkg::FWD_MEM_WB;
        return rv_ctrl_pkg::FWD_NONE;
    endfunction

    logic is_beq_bne;
    logic load_use;
    logic br_hzd;
    logic ex_hit_rs1, ex_hit_rs2;       // EX/MEM writer vs decode rs
    logic wb_hit_rs1, wb_hit_rs2;       // MEM/WB writer vs decode rs
    logic idex_hit_rs1, idex_hit_rs2;   // ID/EX writer vs decode rs

    assign is_beq_bne = is_beq_i | is_bne_i;

    // EX stage operands of the instruction in ID/EX
    assign fwd_a_o = pick_fwd(reg_hit(hzd.ex_mem_reg_w, hzd.ex_mem_rd, hzd.id_ex_rs1),
                              reg_hit(hzd.mem_wb_reg_w, hzd.mem_wb_rd, hzd.id_ex_rs1));
    assign fwd_b_o = pick_fwd(reg_hit(hzd.ex_mem_reg_w, hzd.ex_mem_rd, hzd.id_ex_rs2),
                              reg_hit(hzd.mem_wb_reg_w, hzd.mem_wb_rd, hzd.id_ex_rs2));

    // decode stage operand matches
    assign ex_hit_rs1   = reg_hit(hzd.ex_mem_reg_w, hzd.ex_mem_rd, rs1_i);
    assign ex_hit_rs2   = reg_hit(hzd.ex_mem_reg_w, hzd.ex_mem_rd, rs2_i);
    assign wb_hit_rs1   = reg_hit(hzd.mem_wb_reg_w, hzd.mem_wb_rd, rs1_i);
    assign wb_hit_rs2   = reg_hit(hzd.mem_wb_reg_w, hzd.mem_wb_rd, rs2_i);
    assign idex_hit_rs1 = reg_hit(hzd.id_ex_reg_w, hzd.id_ex_rd, rs1_i);
    assign idex_hit_rs2 = reg_hit(hzd.id_ex_reg_w, hzd.id_ex_rd, rs2_i);

    // a load in EX/MEM has no data yet, fall back to MEM/WB or the RF
    assign cmp_sel_a_o = pick_fwd(ex_hit_rs1 && !hzd.ex_mem_mem_read, wb_hit_rs1);
    assign cmp_sel_b_o = pick_fwd(ex_hit_rs2 && !hzd.ex_mem_mem_read, wb_hit_rs2);

    // load in EX feeding a used source
    assign load_use = hzd.id_ex_mem_read && (hzd.id_ex_rd != '0) &&
                      ((uses_rs1_i && (hzd.id_ex_rd == rs1_i)) ||
                       (uses_rs2_i && (hzd.id_ex_rd == rs2_i)));

    // early compare needs values that are not yet available
    assign br_hzd = is_beq_bne &&
                    (idex_hit_rs1 || idex_hit_rs2 ||
                     (hzd.ex_mem_mem_read && (ex_hit_rs1 || ex_hit_rs2)));

    assign stall_o = load_use | br_hzd;

endmodule

/* src/branch_resolver.sv */
// early branch resolver in ID
// forwarded beq/bne compare, jal redirect and pc relative target
`timescale 1ns/10ps

module branch_resolver (
    input  logic [rv_ctrl_pkg::XLEN-1:0]   pc_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   rs1_data_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   rs2_data_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   ex_mem_result_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   mem_wb_result_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   imm_i,
    input  logic [rv_ctrl_pkg::FWD_W-1:0]  cmp_sel_a_i,
    input  logic [rv_ctrl_pkg::FWD_W-1:0]  cmp_sel_b_i,
    input  logic                           is_jal_i,
    input  logic                           is_beq_i,
    input  logic                           is_bne_i,
    input  logic                           stall_i,
    output logic                           redirect_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]   target_o
);

    // 3:1 operand select by forward code
    function automatic logic [rv_ctrl_pkg::XLEN-1:0] pick_opnd(
        input logic [rv_ctrl_pkg::FWD_W-1:0] sel,
        input logic [rv_ctrl_pkg::XLEN-1:0]  rf_val,
        input logic [rv_ctrl_pkg::XLEN-1:0]  exm_val,
        input logic [rv_ctrl_pkg::XLEN-1:0]  mwb_val
    );
        case (sel)
            rv_ctrl_pkg::FWD_EX_MEM: return exm_val;
            rv_ctrl_pkg::FWD_MEM_WB: return mwb_val;
            default:                 return rf_val;   // FWD_NONE
        endcase
    endfunction

    logic [rv_ctrl_pkg::XLEN-1:0] opnd_a;
    logic [rv_ctrl_pkg::XLEN-1:0] opnd_b;
    logic                         opnd_eq;
    logic                         br_taken;

    assign opnd_a = pick_opnd(cmp_sel_a_i, rs1_data_i, ex_mem_result_i, mem_wb_result_i);
    assign opnd_b = pick_opnd(cmp_sel_b_i, rs2_data_i, ex_mem_result_i, mem_wb_result_i);

    assign opnd_eq = (opnd_a == opnd_b);      // equality only, no sub needed

    // beq on equal, bne on differ
    assign br_taken = (is_beq_i && opnd_eq) || (is_bne_i && !opnd_eq);

    // a stalled instruction redirects on its replay
    assign redirect_o = !stall_i && (is_jal_i || br_taken);

    // imm is already J or B by class
    assign target_o = pc_i + imm_i;

endmodule

/* src/rv_ctrl_top.sv */
// rv_ctrl decode-stage control unit
// forward selects, hazard stall and early jal/beq/bne redirect, one result register
`timescale 1ns/10ps

module rv_ctrl_top (
    input  logic                           clk,
    input  logic                           rst_n_i,
    // request
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   inst_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   pc_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   rs1_data_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   rs2_data_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   ex_mem_result_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]   mem_wb_result_i,
    // pipeline register snapshot
    input  logic [rv_ctrl_pkg::REG_W-1:0]  id_ex_rd_i,
    input  logic [rv_ctrl_pkg::REG_W-1:0]  id_ex_rs1_i,
    input  logic [rv_ctrl_pkg::REG_W-1:0]  id_ex_rs2_i,
    input  logic [rv_ctrl_pkg::REG_W-1:0]  ex_mem_rd_i,
    input  logic [rv_ctrl_pkg::REG_W-1:0]  mem_wb_rd_i,
    input  logic                           id_ex_reg_w_i,
    input  logic                           id_ex_mem_read_i,
    input  logic                           ex_mem_reg_w_i,
    input  logic                           ex_mem_mem_read_i,
    input  logic                           mem_wb_reg_w_i,
    // result
    output logic                           res_valid_o,
    input  logic                           res_ready_i,
    output logic [rv_ctrl_pkg::FWD_W-1:0]  fwd_a_o,
    output logic [rv_ctrl_pkg::FWD_W-1:0]  fwd_b_o,
    output logic                           stall_o,
    output logic                           redirect_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]   target_o
);

    logic [rv_ctrl_pkg::REG_W-1:0] rs1, rs2;
    logic                          uses_rs1, uses_rs2;
    logic                          is_jal, is_beq, is_bne;
    logic [rv_ctrl_pkg::XLEN-1:0]  imm;
    logic [rv_ctrl_pkg::FWD_W-1:0] fwd_a, fwd_b;      // next-state result fields
    logic [rv_ctrl_pkg::FWD_W-1:0] cmp_sel_a, cmp_sel_b;
    logic                          stall, redirect;
    logic [rv_ctrl_pkg::XLEN-1:0]  target;
    logic                          res_valid_q;
    logic                          req_fire;

    hazard_if hzd_bus ();

    // snapshot ports onto the bundle
    assign hzd_bus.id_ex_rd        = id_ex_rd_i;
    assign hzd_bus.id_ex_rs1       = id_ex_rs1_i;
    assign hzd_bus.id_ex_rs2       = id_ex_rs2_i;
    assign hzd_bus.id_ex_reg_w     = id_ex_reg_w_i;
    assign hzd_bus.id_ex_mem_read  = id_ex_mem_read_i;
    assign hzd_bus.ex_mem_rd       = ex_mem_rd_i;
    assign hzd_bus.ex_mem_reg_w    = ex_mem_reg_w_i;
    assign hzd_bus.ex_mem_mem_read = ex_mem_mem_read_i;
    assign hzd_bus.mem_wb_rd       = mem_wb_rd_i;
    assign hzd_bus.mem_wb_reg_w    = mem_wb_reg_w_i;

    inst_classifier u_cls (
        .inst_i     (rv_ctrl_pkg::inst_word_t'(inst_i)),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .uses_rs1_o (uses_rs1),
        .uses_rs2_o (uses_rs2),
        .is_jal_o   (is_jal),
        .is_beq_o   (is_beq),
        .is_bne_o   (is_bne),
        .imm_o      (imm)
    );

    fwd_ctrl u_fwd (
        .hzd         (hzd_bus.hzd),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .uses_rs1_i  (uses_rs1),
        .uses_rs2_i  (uses_rs2),
        .is_beq_i    (is_beq),
        .is_bne_i    (is_bne),
        .fwd_a_o     (fwd_a),
        .fwd_b_o     (fwd_b),
        .cmp_sel_a_o (cmp_sel_a),
        .cmp_sel_b_o (cmp_sel_b),
        .stall_o     (stall)
    );

    branch_resolver u_br (
        .pc_i            (pc_i),
        .rs1_data_i      (rs1_data_i),
        .rs2_data_i      (rs2_data_i),
        .ex_mem_result_i (ex_mem_result_i),
        .mem_wb_result_i (mem_wb_result_i),
        .imm_i           (imm),
        .cmp_sel_a_i     (cmp_sel_a),
        .cmp_sel_b_i     (cmp_sel_b),
        .is_jal_i        (is_jal),
        .is_beq_i        (is_beq),
        .is_bne_i        (is_bne),
        .stall_i         (stall),
        .redirect_o      (redirect),
        .target_o        (target)
    );

    // free slot, or the held result leaves this cycle
    assign req_ready_o = !res_valid_q || res_ready_i;
    assign req_fire    = req_valid_i && req_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (req_fire) begin
            res_valid_q <= 1'b1;              // new result next cycle
        end else if (res_ready_i) begin
            res_valid_q <= 1'b0;              // drained, nothing behind it
        end
    end

    // result payload, held until the next accepted request
    always_ff @(posedge clk) begin
        if (req_fire) begin
            fwd_a_o    <= fwd_a;
            fwd_b_o    <= fwd_b;
            stall_o    <= stall;
            redirect_o <= redirect;
            target_o   <= target;
        end
    end

    assign res_valid_o = res_valid_q;

endmodule

/* test/rv_ctrl_assertions.sv */
// result register checks for rv_ctrl_top
// hold under back-pressure, stall and redirect exclusive, legal forward codes
`timescale 1ns/10ps

module rv_ctrl_assertions (
    input logic                          clk,
    input logic                          rst_n_i,
    input logic                          res_valid_o,
    input logic                          res_ready_i,
    input logic [rv_ctrl_pkg::FWD_W-1:0] fwd_a_o,
    input logic [rv_ctrl_pkg::FWD_W-1:0] fwd_b_o,
    input logic                          stall_o,
    input logic                          redirect_o,
    input logic [rv_ctrl_pkg::XLEN-1:0]  target_o
);

    // held result must not move until taken
    property hold_under_backpressure;
        @(posedge clk) disable iff (!rst_n_i)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(fwd_a_o) &&
            $stable(fwd_b_o) && $stable(stall_o) && $stable(redirect_o) &&
            $stable(target_o));
    endproperty

    a_hold: assert property (hold_under_backpressure)
        else $error("result changed while held under back-pressure");

    // a stalled instruction never redirects
    a_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_o |-> !(stall_o && redirect_o))
        else $error("stall and redirect both high");

    a_fwd_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_o |-> (fwd_a_o != 2'b11) && (fwd_b_o != 2'b11))
        else $error("illegal forward select 11");   // code 11 unused

endmodule

bind rv_ctrl_top rv_ctrl_assertions u_assert (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .fwd_a_o     (fwd_a_o),
    .fwd_b_o     (fwd_b_o),
    .stall_o     (stall_o),
    .redirect_o  (redirect_o),
    .target_o    (target_o)
);

/* test/rv_ctrl_tb.sv */
// testbench for rv_ctrl_top
// random decode requests and back-pressure, results checked against a reference model
`timescale 1ns/10ps

module rv_ctrl_tb;

    localparam logic [31:0] SEED   = 32'hd4e5_4984;
    localparam int CLK_PERIOD      = 8;
    localparam int N_REQ           = 400;
    localparam int TIMEOUT         = 100;     // cycles per wait loop

    typedef struct packed {
        logic [rv_ctrl_pkg::XLEN-1:0]  inst, pc, rs1_data, rs2_data, ex_res, wb_res;
        logic [rv_ctrl_pkg::REG_W-1:0] id_ex_rd, id_ex_rs1, id_ex_rs2, ex_mem_rd, mem_wb_rd;
        logic id_ex_reg_w, id_ex_mem_read, ex_mem_reg_w, ex_mem_mem_read, mem_wb_reg_w;
    } request_t;

    typedef struct packed {
        logic [rv_ctrl_pkg::FWD_W-1:0] fwd_a, fwd_b;
        logic                          stall, redirect;
        logic [rv_ctrl_pkg::XLEN-1:0]  target;
    } result_t;

    logic clk, rst_n_i, req_valid_i, req_ready_o, res_valid_o, res_ready_i;
    logic [rv_ctrl_pkg::XLEN-1:0]  inst_i, pc_i, rs1_data_i, rs2_data_i;
    logic [rv_ctrl_pkg::XLEN-1:0]  ex_mem_result_i, mem_wb_result_i, target_o;
    logic [rv_ctrl_pkg::REG_W-1:0] id_ex_rd_i, id_ex_rs1_i, id_ex_rs2_i, ex_mem_rd_i, mem_wb_rd_i;
    logic id_ex_reg_w_i, id_ex_mem_read_i, ex_mem_reg_w_i, ex_mem_mem_read_i, mem_wb_reg_w_i;
    logic [rv_ctrl_pkg::FWD_W-1:0] fwd_a_o, fwd_b_o;
    logic stall_o, redirect_o;

    result_t exp_q[$];     // expected results in acceptance order
    int      n_checked;

    rv_ctrl_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic verify_fwd_code(input string what, input logic [rv_ctrl_pkg::FWD_W-1:0] got,
                                   input logic [rv_ctrl_pkg::FWD_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic expect_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic compare_target(input logic [rv_ctrl_pkg::XLEN-1:0] got,
                                  input logic [rv_ctrl_pkg::XLEN-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: target_o is %h, expected %h", $time, got, exp));
    endtask

    // writer with nonzero rd landing on the given source
    function automatic logic writer_hits(input logic en, input logic [4:0] rd, input logic [4:0] src);
        return en && (rd != 5'd0) && (rd == src);
    endfunction

    function automatic result_t predict_result(input request_t r);
        result_t     e;
        logic [6:0]  opc;
        logic [4:0]  s1, s2;
        logic        use1, use2, jal, beq, bne, load_use, br_hzd;
        logic [31:0] a, b, imm_j, imm_b;
        opc  = r.inst[6:0];
        s1   = r.inst[19:15];
        s2   = r.inst[24:20];
        jal  = (opc == rv_ctrl_pkg::OPC_JAL);
        beq  = (opc == rv_ctrl_pkg::OPC_BRANCH) && (r.inst[14:12] == rv_ctrl_pkg::F3_BEQ);
        bne  = (opc == rv_ctrl_pkg::OPC_BRANCH) && (r.inst[14:12] == rv_ctrl_pkg::F3_BNE);
        use1 = !(jal || opc == rv_ctrl_pkg::OPC_LUI || opc == rv_ctrl_pkg::OPC_AUIPC);
        use2 = (opc == rv_ctrl_pkg::OPC_BRANCH) || (opc == rv_ctrl_pkg::OPC_STORE) ||
               (opc == rv_ctrl_pkg::OPC_OP);
        // EX operand selects, EX/MEM first
        e.fwd_a = writer_hits(r.ex_mem_reg_w, r.ex_mem_rd, r.id_ex_rs1) ? rv_ctrl_pkg::FWD_EX_MEM :
                  writer_hits(r.mem_wb_reg_w, r.mem_wb_rd, r.id_ex_rs1) ? rv_ctrl_pkg::FWD_MEM_WB :
                  rv_ctrl_pkg::FWD_NONE;
        e.fwd_b = writer_hits(r.ex_mem_reg_w, r.ex_mem_rd, r.id_ex_rs2) ? rv_ctrl_pkg::FWD_EX_MEM :
                  writer_hits(r.mem_wb_reg_w, r.mem_wb_rd, r.id_ex_rs2) ? rv_ctrl_pkg::FWD_MEM_WB :
                  rv_ctrl_pkg::FWD_NONE;
        load_use = r.id_ex_mem_read && (r.id_ex_rd != 5'd0) &&
                   ((use1 && r.id_ex_rd == s1) || (use2 && r.id_ex_rd == s2));
        br_hzd = (beq || bne) &&
                 (writer_hits(r.id_ex_reg_w, r.id_ex_rd, s1) ||
                  writer_hits(r.id_ex_reg_w, r.id_ex_rd, s2) ||
                  writer_hits(r.ex_mem_mem_read && r.ex_mem_reg_w, r.ex_mem_rd, s1) ||
                  writer_hits(r.ex_mem_mem_read && r.ex_mem_reg_w, r.ex_mem_rd, s2));
        e.stall = load_use || br_hzd;
        // compare operands, a load in EX/MEM gives nothing yet
        a = (writer_hits(r.ex_mem_reg_w, r.ex_mem_rd, s1) && !r.ex_mem_mem_read) ? r.ex_res :
            writer_hits(r.mem_wb_reg_w, r.mem_wb_rd, s1) ? r.wb_res : r.rs1_data;
        b = (writer_hits(r.ex_mem_reg_w, r.ex_mem_rd, s2) && !r.ex_mem_mem_read) ? r.ex_res :
            writer_hits(r.mem_wb_reg_w, r.mem_wb_rd, s2) ? r.wb_res : r.rs2_data;
        e.redirect = !e.stall && (jal || (beq && a == b) || (bne && a != b));
        imm_j = {{12{r.inst[31]}}, r.inst[19:12], r.inst[20], r.inst[30:21], 1'b0};
        imm_b = {{20{r.inst[31]}}, r.inst[7], r.inst[30:25], r.inst[11:8], 1'b0};
        e.target = r.pc + (jal ? imm_j : imm_b);
        return e;
    endfunction

    function automatic logic [6:0] pick_opcode();
        case ($urandom_range(0, 10))
            0, 1:    return rv_ctrl_pkg::OPC_BRANCH;     // weighted toward branches
            2:       return rv_ctrl_pkg::OPC_JAL;
            3:       return rv_ctrl_pkg::OPC_JALR;
            4:       return rv_ctrl_pkg::OPC_LOAD;
            5:       return rv_ctrl_pkg::OPC_STORE;
            6:       return rv_ctrl_pkg::OPC_OP;
            7:       return rv_ctrl_pkg::OPC_OP_IMM;
            8:       return rv_ctrl_pkg::OPC_LUI;
            9:       return rv_ctrl_pkg::OPC_AUIPC;
            default: return 7'($urandom_range(0, 127));  // anything else
        endcase
    endfunction

    // small register and data ranges so matches and equal operands are common
    function automatic request_t random_request();
        request_t r;
        r.inst          = $urandom;
        r.inst[6:0]     = pick_opcode();
        r.inst[14:12]   = ($urandom_range(0, 3) != 0) ? 3'($urandom_range(0, 1))
                                                      : 3'($urandom_range(0, 7));
        r.inst[19:15]   = 5'($urandom_range(0, 3));
        r.inst[24:20]   = 5'($urandom_range(0, 3));
        r.pc            = $urandom & 32'hffff_fffc;
        r.rs1_data      = 32'($urandom_range(0, 3));
        r.rs2_data      = 32'($urandom_range(0, 3));
        r.ex_res        = 32'($urandom_range(0, 3));
        r.wb_res        = 32'($urandom_range(0, 3));
        r.id_ex_rd      = 5'($urandom_range(0, 3));
        r.id_ex_rs1     = 5'($urandom_range(0, 3));
        r.id_ex_rs2     = 5'($urandom_range(0, 3));
        r.ex_mem_rd     = 5'($urandom_range(0, 3));
        r.mem_wb_rd     = 5'($urandom_range(0, 3));
        r.id_ex_reg_w     = 1'($urandom_range(0, 1));
        r.id_ex_mem_read  = ($urandom_range(0, 2) == 0);
        r.ex_mem_reg_w    = 1'($urandom_range(0, 1));
        r.ex_mem_mem_read = ($urandom_range(0, 2) == 0);
        r.mem_wb_reg_w    = 1'($urandom_range(0, 1));
        return r;
    endfunction

    task automatic apply_request(input request_t r);
        inst_i            = r.inst;
        pc_i              = r.pc;
        rs1_data_i        = r.rs1_data;
        rs2_data_i        = r.rs2_data;
        ex_mem_result_i   = r.ex_res;
        mem_wb_result_i   = r.wb_res;
        id_ex_rd_i        = r.id_ex_rd;
        id_ex_rs1_i       = r.id_ex_rs1;
        id_ex_rs2_i       = r.id_ex_rs2;
        ex_mem_rd_i       = r.ex_mem_rd;
        mem_wb_rd_i       = r.mem_wb_rd;
        id_ex_reg_w_i     = r.id_ex_reg_w;
        id_ex_mem_read_i  = r.id_ex_mem_read;
        ex_mem_reg_w_i    = r.ex_mem_reg_w;
        ex_mem_mem_read_i = r.ex_mem_mem_read;
        mem_wb_reg_w_i    = r.mem_wb_reg_w;
    endtask

    // handshake lines are stable from just after the falling edge to the next rise
    initial begin : compare_results
        result_t exp;
        logic    exp_valid;
        logic    exp_accept;
        exp_valid = 1'b0;       // low out of reset
        n_checked = 0;
        forever begin
            @(negedge clk);
            #1;
            expect_flag("res_valid_o", res_valid_o, exp_valid);
            expect_flag("req_ready_o", req_ready_o, !exp_valid || res_ready_i);
            if (res_valid_o && res_ready_i) begin
                if (exp_q.size() == 0)
                    abort_run($sformatf("result at %0t ns with no request outstanding", $time));
                exp = exp_q.pop_front();
                verify_fwd_code("fwd_a_o", fwd_a_o, exp.fwd_a);
                verify_fwd_code("fwd_b_o", fwd_b_o, exp.fwd_b);
                expect_flag("stall_o", stall_o, exp.stall);
                expect_flag("redirect_o", redirect_o, exp.redirect);
                if (exp.redirect)
                    compare_target(target_o, exp.target);   // defined only on redirect
                n_checked++;
            end
            // next cycle valid: new accept, or still held
            exp_accept = req_valid_i && (!exp_valid || res_ready_i);
            exp_valid  = exp_accept || (exp_valid && !res_ready_i);
        end
    end

    initial begin : stimulus
        request_t req;
        int       waited;
        logic     accepted;
        void'($urandom(SEED));
        apply_request('0);
        req_valid_i = 1'b0;
        res_ready_i = 1'b0;
        rst_n_i     = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        for (int i = 0; i < N_REQ; i++) begin
            req      = random_request();
            accepted = 1'b0;
            waited   = 0;
            while (!accepted) begin
                @(negedge clk);
                apply_request(req);
                req_valid_i = ($urandom_range(0, 4) != 0);    // idle gaps
                res_ready_i = ($urandom_range(0, 3) != 0);    // random back-pressure
                #1;
                if (req_valid_i && req_ready_o) begin
                    exp_q.push_back(predict_result(req));
                    accepted = 1'b1;
                end else begin
                    waited++;
                    if (waited > TIMEOUT)
                        abort_run($sformatf("timeout: request %0d not accepted", i));
                end
            end
        end
        // drain the last result
        @(negedge clk);
        req_valid_i = 1'b0;
        res_ready_i = 1'b1;
        waited      = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            #2;
            waited++;
            if (waited > TIMEOUT)
                abort_run("timeout: results still outstanding at the end of the run");
        end
        if (n_checked == N_REQ) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run($sformatf("only %0d of %0d results were seen", n_checked, N_REQ));
        end
    end

endmodule

/* rv_ctrl.f */
src/rv_ctrl_pkg.sv
src/hazard_if.sv
src/inst_classifier.sv
src/fwd_ctrl.sv
src/branch_resolver.sv
src/rv_ctrl_top.sv
test/rv_ctrl_assertions.sv
test/rv_ctrl_tb.sv

/* Makefile */
TOP := rv_ctrl_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f rv_ctrl.f --top-module $(TOP)

# the run may stop on an error, the log search decides pass or fail
sim:
	verilator --binary --timing --assert -j 0 -f rv_ctrl.f --top-module $(TOP) -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
